/* Makefile */
TOP := l2_arbiter_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

/* files.f */
verilog/l2_config_pkg.sv
verilog/l2_types_pkg.sv
verilog/l2_fifo.sv
verilog/l2_round_robin.sv
verilog/l2_reservation.sv
verilog/l2_arbiter.sv
test/l2_arbiter_assert.sv
test/l2_arbiter_tb.sv

/* test/l2_arbiter_assert.sv */
`timescale 1ns/1ps

module l2_arbiter_assert
    import l2_config_pkg::*;
    import l2_types_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     req_push [L2_NUM_PORTS],
    input logic     req_full [L2_NUM_PORTS],
    input logic     sc_valid [L2_NUM_PORTS],
    input logic     rd_valid [L2_NUM_PORTS],
    input logic     ret_push [L2_NUM_PORTS],
    input logic     ret_full [L2_NUM_PORTS],
    input logic     mem_valid,
    input logic     advance,
    input port_id_t grantee_id
);

    for (genvar i = 0; i < L2_NUM_PORTS; i++) begin : gen_port
        no_push_full: assert property (@(posedge clk) disable iff (rst)
            req_push[i] |-> !req_full[i]) else $error("push into full input FIFO %0d", i);

        no_return_overflow: assert property (@(posedge clk) disable iff (rst)
            ret_push[i] |-> !ret_full[i]) else $error("return FIFO %0d overflow", i);

        // A strobe held into the next cycle needs a fresh grant to this port
        sc_single_pulse: assert property (@(posedge clk) disable iff (rst)
            sc_valid[i] |=> !sc_valid[i] || $past(advance && (grantee_id == port_id_t'(i))))
            else $error("sc_valid %0d held without a new grant", i);

        quiet_in_reset: assert property (@(posedge clk)
            $past(rst) |-> !mem_valid && !rd_valid[i] && !sc_valid[i])
            else $error("outputs of port %0d active around reset", i);
    end

endmodule

bind l2_arbiter l2_arbiter_assert l2_arbiter_assert_i (
    .clk        (clk),
    .rst        (rst),
    .req_push   (req_push),
    .req_full   (req_full),
    .sc_valid   (sc_valid),
    .rd_valid   (rd_valid),
    .ret_push   (ret_push),
    .ret_full   (ret_full),
    .mem_valid  (mem_valid),
    .advance    (advance),
    .grantee_id (grantee_id)
);

/* test/l2_arbiter_tb.sv */
`timescale 1ns/1ps

module l2_arbiter_tb;

    import l2_config_pkg::*;
    import l2_types_pkg::*;

    localparam int NUM_REQS = 200;
    localparam int ADDR_RANGE = 8;
    localparam int TIMEOUT_CYCLES = NUM_REQS * L2_NUM_PORTS * 20;
    // Memory holds off mem_pop for a while in every period
    localparam int STALL_PERIOD = 150;
    localparam int STALL_LEN = 40;

    logic clk, rst;
    logic    req_push [L2_NUM_PORTS];
    addr_t   req_addr [L2_NUM_PORTS];
    op_t     req_op [L2_NUM_PORTS];
    data_t   req_wdata [L2_NUM_PORTS];
    sub_id_t req_sub_id [L2_NUM_PORTS];
    logic    req_full [L2_NUM_PORTS];
    logic    sc_valid [L2_NUM_PORTS];
    logic    sc_result [L2_NUM_PORTS];
    logic    rd_valid [L2_NUM_PORTS];
    data_t   rd_data [L2_NUM_PORTS];
    sub_id_t rd_sub_id [L2_NUM_PORTS];
    logic    rd_ack [L2_NUM_PORTS];
    logic    mem_valid, mem_abort, mem_pop, mem_rd_valid;
    addr_t   mem_addr;
    op_t     mem_op;
    data_t   mem_wdata, mem_rd_data;
    mem_id_t mem_id, mem_rd_id;

    // Reference state
    addr_t   exp_addr [L2_NUM_PORTS][$];
    op_t     exp_op [L2_NUM_PORTS][$];
    data_t   exp_wdata [L2_NUM_PORTS][$];
    sub_id_t exp_sub [L2_NUM_PORTS][$];
    logic    got_sc [L2_NUM_PORTS][$];
    sub_id_t ret_sub [L2_NUM_PORTS][$];
    data_t   ret_data [L2_NUM_PORTS][$];
    mem_id_t ans_id [$];
    data_t   ans_data [$];
    int      ans_due [$];
    logic    resv_valid [L2_NUM_PORTS];
    addr_t   resv_addr [L2_NUM_PORTS];
    data_t   mem_words [ADDR_RANGE];
    int sent [L2_NUM_PORTS];
    int pending [L2_NUM_PORTS];
    int outstanding [L2_NUM_PORTS];
    int errors, checks, cycle, last_due, streak, streak_port;
    logic saw_full, done;

    l2_arbiter l2_arbiter_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic complain(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // One memory transfer, checked against the reservation rules in grant order
    task automatic take_transfer();
        int q;
        int due;
        addr_t a;
        op_t o;
        sub_id_t s;
        logic abort_exp, store, contested;
        q = int'(mem_id[L2_PORT_ID_W+L2_SUB_ID_W-1 -: L2_PORT_ID_W]);
        if (q >= L2_NUM_PORTS || exp_addr[q].size() == 0) begin
            complain("memory request from a port with nothing pushed");
            return;
        end
        a = exp_addr[q].pop_front();
        o = exp_op[q].pop_front();
        s = exp_sub[q].pop_front();
        check("mem_addr", mem_addr, a);
        check("mem_op", mem_op, o);
        check("mem_wdata", mem_wdata, exp_wdata[q].pop_front());
        check("mem_id.sub", mem_id[L2_SUB_ID_W-1:0], s);
        pending[q]--;
        abort_exp = (o == OP_SC) && !(resv_valid[q] && resv_addr[q] == a);
        check("mem_abort", mem_abort, abort_exp);
        if (o == OP_SC) begin
            if (got_sc[q].size() == 0) begin
                complain("SC reached memory without an sc_valid pulse");
            end else begin
                check("sc_result", got_sc[q].pop_front(), !abort_exp);
            end
        end
        store = (o == OP_WRITE) || (o == OP_SC && !abort_exp);
        for (int p = 0; p < L2_NUM_PORTS; p++) begin
            if (store && resv_addr[p] == a) begin
                resv_valid[p] = 1'b0;
            end
        end
        if (o == OP_LR) begin
            resv_valid[q] = 1'b1;
            resv_addr[q] = a;
        end
        if (o == OP_SC) begin
            resv_valid[q] = 1'b0;
        end
        if (store) begin
            mem_words[a] = mem_wdata;
        end
        if (o == OP_READ || o == OP_LR) begin
            due = cycle + $urandom_range(1, 4);
            // Answers stay in order behind the previous one
            if (due <= last_due) begin
                due = last_due + 1;
            end
            ans_id.push_back(mem_id);
            ans_data.push_back(mem_words[a]);
            ans_due.push_back(due);
            last_due = due;
            ret_sub[q].push_back(s);
            ret_data[q].push_back(mem_words[a]);
        end
        // Entries already queued in the memory FIFO may come out in a run
        contested = 1'b0;
        for (int p = 0; p < L2_NUM_PORTS; p++) begin
            if (p != q && pending[p] > L2_MEM_FIFO_DEPTH) begin
                contested = 1'b1;
            end
        end
        if (!contested) begin
            streak = 0;
        end else if (q == streak_port) begin
            streak++;
        end else begin
            streak_port = q;
            streak = 1;
        end
        if (streak > L2_NUM_PORTS + L2_MEM_FIFO_DEPTH) begin
            complain("one port kept the memory port while the other waited");
        end
    endtask

    // Everything that transfers on the coming rising edge
    task automatic observe();
        for (int p = 0; p < L2_NUM_PORTS; p++) begin
            saw_full |= req_full[p];
            if (sc_valid[p]) begin
                got_sc[p].push_back(sc_result[p]);
            end
            if (rd_valid[p] && rd_ack[p]) begin
                if (ret_sub[p].size() == 0) begin
                    complain("read data returned on a port with no read outstanding");
                end else begin
                    check("rd_sub_id", rd_sub_id[p], ret_sub[p].pop_front());
                    check("rd_data", rd_data[p], ret_data[p].pop_front());
                    outstanding[p]--;
                end
            end
        end
        if (mem_valid && mem_pop) begin
            take_transfer();
        end
    endtask

    task automatic drive();
        op_t o;
        mem_pop = ((cycle % STALL_PERIOD) < STALL_LEN) ? 1'b0 : ($urandom_range(0, 3) != 0);
        mem_rd_valid = 1'b0;
        if (ans_due.size() != 0 && ans_due[0] <= cycle) begin
            mem_rd_valid = 1'b1;
            mem_rd_id = ans_id.pop_front();
            mem_rd_data = ans_data.pop_front();
            void'(ans_due.pop_front());
        end
        for (int p = 0; p < L2_NUM_PORTS; p++) begin
            rd_ack[p] = ($urandom_range(0, 3) != 0);
            req_push[p] = 1'b0;
            if (sent[p] < NUM_REQS && !req_full[p] && outstanding[p] < L2_RETURN_FIFO_DEPTH
                && $urandom_range(0, 3) != 0) begin
                o = op_t'($urandom_range(0, 3));
                req_push[p] = 1'b1;
                req_op[p] = o;
                req_addr[p] = addr_t'($urandom_range(0, ADDR_RANGE - 1));
                req_wdata[p] = $urandom;
                req_sub_id[p] = sub_id_t'($urandom_range(0, 3));
                exp_addr[p].push_back(req_addr[p]);
                exp_op[p].push_back(o);
                exp_wdata[p].push_back(req_wdata[p]);
                exp_sub[p].push_back(req_sub_id[p]);
                sent[p]++;
                pending[p]++;
                if (o == OP_READ || o == OP_LR) begin
                    outstanding[p]++;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'hd3ab173e));
        rst = 1'b1;
        mem_pop = 1'b0;
        mem_rd_valid = 1'b0;
        mem_rd_id = '0;
        mem_rd_data = '0;
        for (int p = 0; p < L2_NUM_PORTS; p++) begin
            req_push[p] = 1'b0;
            req_addr[p] = '0;
            req_op[p] = OP_READ;
            req_wdata[p] = '0;
            req_sub_id[p] = '0;
            rd_ack[p] = 1'b0;
            resv_valid[p] = 1'b0;
            resv_addr[p] = '0;
            sent[p] = 0;
            pending[p] = 0;
            outstanding[p] = 0;
        end
        // Memory starts from the same fill as the model
        for (int i = 0; i < ADDR_RANGE; i++) begin
            mem_words[i] = 32'h5a000000 ^ (i * 32'h01010101);
        end
        errors = 0;
        checks = 0;
        cycle = 0;
        last_due = 0;
        streak = 0;
        streak_port = 0;
        saw_full = 1'b0;
        done = 1'b0;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;
        while (!done && cycle < TIMEOUT_CYCLES) begin
            @(negedge clk);
            observe();
            @(posedge clk);
            cycle++;
            #2;
            drive();
            done = !mem_valid && ans_due.size() == 0;
            for (int p = 0; p < L2_NUM_PORTS; p++) begin
                done &= sent[p] == NUM_REQS && pending[p] == 0 && !rd_valid[p]
                        && ret_sub[p].size() == 0 && got_sc[p].size() == 0 && !req_push[p];
            end
        end
        if (!done) begin
            complain($sformatf("timeout after %0d cycles with requests still in flight", cycle));
        end
        if (!saw_full) begin
            complain("req_full never rose while memory was stalled");
        end
        $display("Finished after %0d cycles: %0d checks, %0d errors", cycle, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verilog/l2_arbiter.sv */
`timescale 1ns/1ps

module l2_arbiter
    import l2_config_pkg::*;
    import l2_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // Requester side
    input  logic    req_push   [L2_NUM_PORTS],
    input  addr_t   req_addr   [L2_NUM_PORTS],
    input  op_t     req_op     [L2_NUM_PORTS],
    input  data_t   req_wdata  [L2_NUM_PORTS],
    input  sub_id_t req_sub_id [L2_NUM_PORTS],
    output logic    req_full   [L2_NUM_PORTS],

    output logic    sc_valid   [L2_NUM_PORTS],
    output logic    sc_result  [L2_NUM_PORTS],

    output logic    rd_valid   [L2_NUM_PORTS],
    output data_t   rd_data    [L2_NUM_PORTS],
    output sub_id_t rd_sub_id  [L2_NUM_PORTS],
    input  logic    rd_ack     [L2_NUM_PORTS],

    // Memory side
    output logic    mem_valid,
    output addr_t   mem_addr,
    output op_t     mem_op,
    output data_t   mem_wdata,
    output mem_id_t mem_id,
    output logic    mem_abort,
    input  logic    mem_pop,

    input  logic    mem_rd_valid,
    input  mem_id_t mem_rd_id,
    input  data_t   mem_rd_data
);

    localparam int REQ_W = $bits(addr_t) + $bits(op_t) + $bits(data_t) + $bits(sub_id_t);
    localparam int MEM_REQ_W = $bits(addr_t) + $bits(op_t) + $bits(data_t) + $bits(mem_id_t) + 1;
    localparam int MEM_RET_W = $bits(mem_id_t) + $bits(data_t);
    localparam int RET_W = $bits(sub_id_t) + $bits(data_t);

    // Head of each input FIFO
    logic [REQ_W-1:0]        in_out   [L2_NUM_PORTS];
    logic [L2_NUM_PORTS-1:0] in_valid;
    addr_t                   in_addr  [L2_NUM_PORTS];
    op_t                     in_op    [L2_NUM_PORTS];
    data_t                   in_wdata [L2_NUM_PORTS];
    sub_id_t                 in_sub_id[L2_NUM_PORTS];

    logic     grantee_valid;
    port_id_t grantee_id;
    logic     advance;
    logic     sc_fail;

    logic [MEM_REQ_W-1:0] mem_req_out;
    logic                 mem_req_full;

    logic [MEM_RET_W-1:0] mem_ret_out;
    logic                 mem_ret_valid;
    port_id_t             ret_port;
    sub_id_t              ret_sub_id;
    data_t                ret_data;

    logic [RET_W-1:0] ret_out  [L2_NUM_PORTS];
    logic             ret_push [L2_NUM_PORTS];
    logic             ret_full [L2_NUM_PORTS];

    // Input request FIFOs
    for (genvar i = 0; i < L2_NUM_PORTS; i++) begin : gen_input
        l2_fifo #(.WIDTH(REQ_W), .DEPTH(L2_INPUT_FIFO_DEPTH)) input_fifo_i (
            .clk      (clk),
            .rst      (rst),
            .push     (req_push[i]),
            .data_in  ({req_addr[i], req_op[i], req_wdata[i], req_sub_id[i]}),
            .pop      (advance && (grantee_id == port_id_t'(i))),
            .data_out (in_out[i]),
            .valid    (in_valid[i]),
            .full     (req_full[i])
        );

        assign {in_addr[i], in_op[i], in_wdata[i], in_sub_id[i]} = in_out[i];
    end

    l2_round_robin round_robin_i (
        .clk           (clk),
        .rst           (rst),
        .requests      (in_valid),
        .advance       (advance),
        .grantee_valid (grantee_valid),
        .grantee_id    (grantee_id)
    );

    // One grant per cycle while the memory FIFO has room
    assign advance = grantee_valid && !mem_req_full;

    l2_reservation reservation_i (
        .clk     (clk),
        .rst     (rst),
        .strobe  (advance),
        .port    (grantee_id),
        .addr    (in_addr[grantee_id]),
        .op      (in_op[grantee_id]),
        .sc_fail (sc_fail)
    );

    // Memory request FIFO, a failed SC rides along with abort set
    l2_fifo #(.WIDTH(MEM_REQ_W), .DEPTH(L2_MEM_FIFO_DEPTH)) mem_req_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (advance),
        .data_in  ({in_addr[grantee_id], in_op[grantee_id], in_wdata[grantee_id],
                    grantee_id, in_sub_id[grantee_id], sc_fail}),
        .pop      (mem_pop && mem_valid),
        .data_out (mem_req_out),
        .valid    (mem_valid),
        .full     (mem_req_full)
    );

    assign {mem_addr, mem_op, mem_wdata, mem_id, mem_abort} = mem_req_out;

    // SC outcome lands the cycle after the grant
    always_ff @(posedge clk) begin
        for (int p = 0; p < L2_NUM_PORTS; p++) begin
            if (rst) begin
                sc_valid[p] <= 1'b0;
            end else begin
                sc_valid[p] <= advance && (in_op[grantee_id] == OP_SC)
                               && (grantee_id == port_id_t'(p));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < L2_NUM_PORTS; p++) begin
            if (advance && (grantee_id == port_id_t'(p))) begin
                sc_result[p] <= !sc_fail;
            end
        end
    end

    // Memory return FIFO drains itself every cycle it holds data
    l2_fifo #(.WIDTH(MEM_RET_W), .DEPTH(L2_MEM_FIFO_DEPTH)) mem_ret_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (mem_rd_valid),
        .data_in  ({mem_rd_id, mem_rd_data}),
        .pop      (mem_ret_valid),
        .data_out (mem_ret_out),
        .valid    (mem_ret_valid),
        .full     ()
    );

    assign {ret_port, ret_sub_id, ret_data} = mem_ret_out;

    // Per-port return FIFOs, selected by the port field of the id
    for (genvar i = 0; i < L2_NUM_PORTS; i++) begin : gen_return
        assign ret_push[i] = mem_ret_valid && (ret_port == port_id_t'(i));

        l2_fifo #(.WIDTH(RET_W), .DEPTH(L2_RETURN_FIFO_DEPTH)) return_fifo_i (
            .clk      (clk),
            .rst      (rst),
            .push     (ret_push[i]),
            .data_in  ({ret_sub_id, ret_data}),
            .pop      (rd_ack[i] && rd_valid[i]),
            .data_out (ret_out[i]),
            .valid    (rd_valid[i]),
            .full     (ret_full[i])
        );

        assign {rd_sub_id[i], rd_data[i]} = ret_out[i];
    end

endmodule

/* verilog/l2_config_pkg.sv */
package l2_config_pkg;

    // Requesters sharing the one memory port
    localparam int L2_NUM_PORTS = 2;

    // Port number field of a memory id, never narrower than one bit
    localparam int L2_PORT_ID_W = (L2_NUM_PORTS > 1) ? $clog2(L2_NUM_PORTS) : 1;

    // Per-requester request buffering
    localparam int L2_INPUT_FIFO_DEPTH = 4;

    // Shared by the memory request and memory return FIFOs
    localparam int L2_MEM_FIFO_DEPTH = 4;

    // Read data waiting for each requester to ack
    localparam int L2_RETURN_FIFO_DEPTH = 4;

endpackage

/* verilog/l2_fifo.sv */
`timescale 1ns/1ps

module l2_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] data_in,
    input  logic             pop,
    output logic [WIDTH-1:0] data_out,
    output logic             valid,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] storage [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wraps at DEPTH so odd depths work too
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            storage[wr_ptr] <= data_in;
        end
    end

    // Head entry is read straight from storage
    assign data_out = storage[rd_ptr];

    assign valid = (count != '0);
    assign full = (count == CNT_W'(DEPTH));

endmodule

/* verilog/l2_reservation.sv */
`timescale 1ns/1ps

module l2_reservation
    import l2_config_pkg::*;
    import l2_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     strobe,
    input  port_id_t port,
    input  addr_t    addr,
    input  op_t      op,
    output logic     sc_fail
);

    // One reserved word per port
    logic [L2_NUM_PORTS-1:0] resv_valid;
    addr_t                   resv_addr [L2_NUM_PORTS];

    logic is_sc;
    logic own_match;
    logic is_store;

    assign is_sc = (op == OP_SC);
    assign own_match = resv_valid[port] && (resv_addr[port] == addr);

    // SC without a live reservation of its own on this word
    assign sc_fail = is_sc && !own_match;

    // Only stores that reach memory break reservations
    assign is_store = (op == OP_WRITE) || (is_sc && own_match);

    always_ff @(posedge clk) begin
        if (rst) begin
            resv_valid <= '0;
        end else if (strobe) begin
            for (int p = 0; p < L2_NUM_PORTS; p++) begin
                if (is_store && (resv_addr[p] == addr)) begin
                    resv_valid[p] <= 1'b0;
                end
            end
            if (op == OP_LR) begin
                resv_valid[port] <= 1'b1;
            end
            // Any SC consumes its own reservation, pass or fail
            if (is_sc) begin
                resv_valid[port] <= 1'b0;
            end
        end
    end

    // Address only matters while its valid bit is set
    always_ff @(posedge clk) begin
        if (strobe && (op == OP_LR)) begin
            resv_addr[port] <= addr;
        end
    end

endmodule

/* verilog/l2_round_robin.sv */
`timescale 1ns/1ps

module l2_round_robin
    import l2_config_pkg::*;
    import l2_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [L2_NUM_PORTS-1:0] requests,
    input  logic                    advance,
    output logic                    grantee_valid,
    output port_id_t                grantee_id
);

    // Port with the highest priority this cycle
    port_id_t priority_ptr;

    // Scan from the farthest offset back, so the nearest requester wins
    always_comb begin
        int idx;
        grantee_valid = 1'b0;
        grantee_id = priority_ptr;
        for (int k = L2_NUM_PORTS - 1; k >= 0; k--) begin
            idx = int'(priority_ptr) + k;
            if (idx >= L2_NUM_PORTS) begin
                idx = idx - L2_NUM_PORTS;
            end
            if (requests[idx]) begin
                grantee_valid = 1'b1;
                grantee_id = port_id_t'(idx);
            end
        end
    end

    // Priority moves to the port after the one just served
    always_ff @(posedge clk) begin
        if (rst) begin
            priority_ptr <= '0;
        end else if (advance) begin
            if (grantee_id == port_id_t'(L2_NUM_PORTS - 1)) begin
                priority_ptr <= '0;
            end else begin
                priority_ptr <= grantee_id + 1'b1;
            end
        end
    end

endmodule

/* verilog/l2_types_pkg.sv */
package l2_types_pkg;

    import l2_config_pkg::*;

    // Field widths
    localparam int L2_ADDR_W = 30;
    localparam int L2_DATA_W = 32;
    localparam int L2_SUB_ID_W = 2;
    localparam int L2_OP_W = 2;

    // Word address, the two byte offset bits are dropped
    typedef logic [L2_ADDR_W-1:0] addr_t;
    typedef logic [L2_DATA_W-1:0] data_t;

    // Requester's own transaction tag
    typedef logic [L2_SUB_ID_W-1:0] sub_id_t;

    typedef logic [L2_PORT_ID_W-1:0] port_id_t;

    // Port number in the upper bits, sub id below
    typedef logic [L2_PORT_ID_W+L2_SUB_ID_W-1:0] mem_id_t;

    typedef logic [L2_OP_W-1:0] op_t;

    // Operation codes
    localparam op_t OP_READ = 2'd0;
    localparam op_t OP_WRITE = 2'd1;
    localparam op_t OP_LR = 2'd2;
    localparam op_t OP_SC = 2'd3;

endpackage
